// ==== Makefile ====
# Verilator build and run of the memory buffer testbench

VERILATOR ?= verilator
TOP       ?= mbxMemBufferTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+verilog
verilog/mbxBufferPkg.sv
verilog/mbxDiagPkg.sv
verilog/mbxWordRequest.sv
verilog/mbxSlotStatus.sv
verilog/mbxDrainSelect.sv
verilog/mbxDiagRead.sv
verilog/mbxMemBuffer.sv
bench/mbxMemBufferTb.sv

// ==== bench/mbxMemBufferTb.sv ====
// Testbench for the memory buffer with clock, reset, reference model, compare tasks and tests

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxMemBufferTb
  import mbxBufferPkg::*;
  import mbxDiagPkg::*;
();

  logic clk, rstN, coreWdStrobe, cacheLoad, parBitIn, readRq, oneWordRd;
  logic memBusy, memAck, diagEn, memReq;
  mbWordIdxT coreAdr, rdAdr, mbSel;
  mbWordMaskT cacheWdMask, wdNeeded, cshWdVal, memRdMask;
  mbSourceT mbInSel;
  diagSelT diagSel;
  diagWordT diagData;
  string testName;
  int seed;
  logic [31:0] r, r2;
  mbSourceT srcList [5];

  // Reference model state
  mbWordMaskT mPend, mPar, mKnown, mLoad, mRdMask;
  mbDataCodeT mCode [`MBX_WORDS];
  mbWordIdxT mSel;
  logic mLoadPar;
  mbSourceT mLoadSrc;

  mbxMemBuffer mbxMemBuffer_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic mbDataCodeT codeOf(input mbSourceT src);
    case (src)
      cacheData: return codeCache;
      arData:    return codeAr;
      memData:   return codeMem;
      default:   return codeExt;
    endcase
  endfunction

  function automatic void resetModel();
    mPend = '0;
    mKnown = '0;
    mLoad = '0;
    mRdMask = '0;
    mSel = '0;
    mLoadPar = 1'b0;
    mLoadSrc = cacheData;
  endfunction

  // One clock edge of the buffer, using the inputs sampled at that edge
  function automatic void stepModel();
    mbWordMaskT clr;
    mbWordMaskT nextLoad;
    clr = '0;
    if (memAck && mPend[mSel]) clr[mSel] = 1'b1;
    for (int i = 0; i < `MBX_WORDS; i++) begin
      if (mLoad[i]) begin
        mPar[i] = mLoadPar;
        mCode[i] = codeOf(mLoadSrc);
        mKnown[i] = 1'b1;
      end
    end
    if (!memBusy) begin
      mSel = '0;
      for (int i = `MBX_WORDS - 1; i >= 0; i--) if (mPend[i]) mSel = mbWordIdxT'(i);
    end
    // Load beats clear on the same word
    mPend = (mPend & ~clr) | mLoad;
    nextLoad = '0;
    if (coreWdStrobe) nextLoad[coreAdr] = 1'b1;
    if (cacheLoad) nextLoad = nextLoad | (cacheWdMask & wdNeeded);
    mLoad = nextLoad;
    mLoadPar = parBitIn;
    mLoadSrc = mbInSel;
    mRdMask = '0;
    if (oneWordRd) mRdMask[rdAdr] = 1'b1;
    else if (readRq) mRdMask = ~cshWdVal & wdNeeded;
  endfunction

  function automatic diagWordT expectedDiag();
    diagWordT d;
    case (diagSel)
      slot0, slot1, slot2, slot3:
        d = {mPend[diagSel[1:0]], mPar[diagSel[1:0]], mCode[diagSel[1:0]]};
      pendMask:   d = mPend;
      drainState: d = {mSel, |mPend, 1'b0};
      rdMask:     d = mRdMask;
      default:    d = '0;
    endcase
    return diagEn ? d : '0;
  endfunction

  always @(posedge clk or negedge rstN) begin
    if (!rstN) resetModel();
    else stepModel();
  end

  task automatic abortRun();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkMask(input string what, input mbWordMaskT exp, input mbWordMaskT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", testName, what, exp, act);
      abortRun();
    end
  endtask

  task automatic checkSel(input string what, input mbWordIdxT exp, input mbWordIdxT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", testName, what, exp, act);
      abortRun();
    end
  endtask

  task automatic checkReq(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", testName, what, exp, act);
      abortRun();
    end
  endtask

  task automatic checkDiag(input string what, input diagWordT exp, input diagWordT act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", testName, what, exp, act);
      abortRun();
    end
  endtask

  // Every cycle after reset the DUT must track the model
  always @(negedge clk) begin
    if (rstN) begin
      checkReq("memReq", |mPend, memReq);
      checkSel("mbSel", mSel, mbSel);
      checkMask("memRdMask", mRdMask, memRdMask);
      // A slot never loaded holds no defined status
      if (!(diagEn && diagSel <= slot3 && !mKnown[diagSel[1:0]]))
        checkDiag("diagData", expectedDiag(), diagData);
    end
  end

  task automatic waitForSel(input mbWordIdxT want, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (mbSel !== want) begin
      n++;
      if (n > limit) begin
        $display("Timeout in %s: drain select never reached word %0d", testName, want);
        abortRun();
      end
      @(negedge clk);
    end
  endtask

  task automatic waitForDiag(input diagWordT want, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (diagData !== want) begin
      n++;
      if (n > limit) begin
        $display("Timeout in %s: diagnostic lane never showed %b", testName, want);
        abortRun();
      end
      @(negedge clk);
    end
  endtask

  // Ack one word at a time until nothing is pending
  task automatic drainAll(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (memReq) begin
      n++;
      if (n > limit) begin
        $display("Timeout in %s: buffer never drained", testName);
        abortRun();
      end
      @(posedge clk);
      memAck <= 1'b1;
      @(posedge clk);
      memAck <= 1'b0;
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  initial begin
    seed = 33;
    srcList = '{cacheData, arData, chanData, memData, ccwData};
    rstN = 1'b0;
    {coreWdStrobe, cacheLoad, parBitIn, readRq, oneWordRd, memBusy, memAck, diagEn} = '0;
    {coreAdr, rdAdr, cacheWdMask, wdNeeded, cshWdVal} = '0;
    mbInSel = cacheData;
    diagSel = idle;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;

    testName = "reset";
    @(negedge clk);
    checkReq("memReq", 1'b0, memReq);
    checkMask("memRdMask", 4'b0000, memRdMask);
    checkSel("mbSel", 2'd0, mbSel);
    checkDiag("diagData", 4'b0000, diagData);

    testName = "core strobes";
    @(posedge clk);
    {coreWdStrobe, coreAdr, mbInSel, parBitIn} <= {1'b1, 2'd2, arData, 1'b1};
    {diagEn, diagSel} <= {1'b1, pendMask};
    @(posedge clk);
    coreAdr <= 2'd1;
    @(posedge clk);
    coreWdStrobe <= 1'b0;
    waitForSel(2'd1, 10);
    checkDiag("pending", 4'b0110, diagData);
    @(posedge clk);
    memAck <= 1'b1;
    @(posedge clk);
    memAck <= 1'b0;
    waitForSel(2'd2, 10);
    @(posedge clk);
    memAck <= 1'b1;
    @(posedge clk);
    memAck <= 1'b0;
    waitForDiag(4'b0000, 10);
    checkReq("memReq", 1'b0, memReq);

    // Buffer is empty when memory goes busy, so the select sits on word 0
    testName = "cache load under busy";
    @(posedge clk);
    memBusy <= 1'b1;
    @(posedge clk);
    {cacheLoad, cacheWdMask, wdNeeded, mbInSel} <= {1'b1, 4'b1110, 4'b0110, memData};
    @(posedge clk);
    {cacheLoad, coreWdStrobe, coreAdr, mbInSel} <= {1'b0, 1'b1, 2'd3, ccwData};
    @(posedge clk);
    coreWdStrobe <= 1'b0;
    waitForDiag(4'b1110, 10);
    checkSel("held select", 2'd0, mbSel);
    @(posedge clk);
    memBusy <= 1'b0;
    waitForSel(2'd1, 10);
    drainAll(20);

    testName = "read mask";
    @(posedge clk);
    {oneWordRd, rdAdr, readRq, cshWdVal, wdNeeded} <= {1'b1, 2'd3, 1'b1, 4'b0101, 4'b1110};
    @(posedge clk);
    @(negedge clk);
    checkMask("one word", 4'b1000, memRdMask);
    @(posedge clk);
    oneWordRd <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkMask("cache miss words", 4'b1010, memRdMask);
    @(posedge clk);
    readRq <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkMask("no request", 4'b0000, memRdMask);

    testName = "diagnostic readout";
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      {coreWdStrobe, coreAdr, parBitIn} <= {1'b1, mbWordIdxT'(k % 4), k[0]};
      mbInSel <= srcList[k];
      diagSel <= diagSelT'(3'(k % 4));
      @(posedge clk);
      coreWdStrobe <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      checkDiag("slot nibble", {1'b1, k[0], codeOf(srcList[k])}, diagData);
    end
    @(posedge clk);
    diagSel <= pendMask;
    @(negedge clk);
    checkDiag("pending", 4'b1111, diagData);
    @(posedge clk);
    diagSel <= idle;
    @(negedge clk);
    checkDiag("idle", 4'b0000, diagData);
    @(posedge clk);
    {diagEn, diagSel} <= {1'b0, pendMask};
    @(negedge clk);
    checkDiag("disabled", 4'b0000, diagData);
    drainAll(20);

    testName = "random mix";
    for (int c = 0; c < 300; c++) begin
      @(posedge clk);
      r = $random(seed);
      r2 = $random(seed);
      {coreWdStrobe, coreAdr, cacheLoad, cacheWdMask, wdNeeded} <= r[11:0];
      {parBitIn, readRq, oneWordRd, cshWdVal, rdAdr} <= r[20:12];
      {memAck, memBusy, diagEn} <= {r[21], r[22] & r[23], r[24]};
      mbInSel <= srcList[r2[7:4] % 5];
      diagSel <= diagSelT'(r2[2:0]);
    end
    // Stop new loads so the buffer can empty
    @(posedge clk);
    {coreWdStrobe, cacheLoad, readRq, oneWordRd, memAck, memBusy} <= '0;
    @(posedge clk);
    drainAll(20);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verilog/mbxBufferPkg.sv ====
// Buffer word mask, word index, MB input source, data code and slot status types

`include "mbx_config.svh"

package mbxBufferPkg;

  // One bit per buffer word, bit 0 drains first
  typedef logic [`MBX_WORDS-1:0] mbWordMaskT;

  typedef logic [`MBX_IDX_W-1:0] mbWordIdxT;

  // MB input select encoding
  typedef enum logic [2:0] {
    cacheData = 3'd0,
    arData    = 3'd2,
    chanData  = 3'd3,
    memData   = 3'd4,
    ccwData   = 3'd6
  } mbSourceT;

  // Where the word data came from
  typedef enum logic [1:0] {
    codeCache = 2'd0,
    codeAr    = 2'd1,
    codeMem   = 2'd2,
    codeExt   = 2'd3
  } mbDataCodeT;

  // Slot status, one nibble per word
  typedef union packed {
    logic [3:0] raw;
    struct packed {
      logic       pending;
      logic       parity;
      mbDataCodeT dataCode;
    } fields;
  } mbSlotT;

endpackage

// ==== verilog/mbxDiagPkg.sv ====
// Diagnostic select encoding and diagnostic lane type

`include "mbx_config.svh"

package mbxDiagPkg;

  //////////////////////////////////////////////////
  // Diagnostic select
  //  0..3  raw status nibble of one slot
  //  4     pending mask
  //  5     drain select and memory request
  //  6     memory read request mask
  //  7     nothing, lane reads zero
  //////////////////////////////////////////////////
  typedef enum logic [`MBX_DIAG_SEL_W-1:0] {
    slot0      = 3'd0,
    slot1      = 3'd1,
    slot2      = 3'd2,
    slot3      = 3'd3,
    pendMask   = 3'd4,
    drainState = 3'd5,
    rdMask     = 3'd6,
    idle       = 3'd7
  } diagSelT;

  // Lane driven onto the diagnostic bus
  typedef logic [`MBX_DIAG_W-1:0] diagWordT;

endpackage

// ==== verilog/mbxDiagRead.sv ====
// Diagnostic readout: 8-way mux of buffer state onto the diagnostic lane

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxDiagRead
  import mbxBufferPkg::*;
  import mbxDiagPkg::*;
(
  input  logic                    diagEn,
  input  diagSelT                 diagSel,
  input  mbSlotT [`MBX_WORDS-1:0] slots,
  input  mbWordMaskT              pending,
  input  mbWordMaskT              memRdMask,
  input  mbWordIdxT               mbSel,
  input  logic                    memReq,
  output diagWordT                diagData
);

  diagWordT laneMux;

  always_comb begin
    case (diagSel)
      slot0:      laneMux = slots[0].raw;
      slot1:      laneMux = slots[1].raw;
      slot2:      laneMux = slots[2].raw;
      slot3:      laneMux = slots[3].raw;
      pendMask:   laneMux = pending;
      // Select on top, request below it, low bit unused
      drainState: laneMux = {mbSel, memReq, 1'b0};
      rdMask:     laneMux = memRdMask;
      idle:       laneMux = '0;
      default:    laneMux = '0;
    endcase
  end

  // Lane is quiet unless a diagnostic read is in progress
  assign diagData = diagEn ? laneMux : '0;

endmodule

// ==== verilog/mbxDrainSelect.sv ====
// Drain selector: lowest pending word to memory, held while memory is busy

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxDrainSelect
  import mbxBufferPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  mbWordMaskT pending,
  input  logic       memBusy,
  input  logic       memAck,
  output mbWordIdxT  mbSel,
  output logic       memReq,
  output mbWordMaskT clrMask
);

  mbWordIdxT nextSel;

  // Lowest index wins, zero when nothing waits
  always_comb begin
    nextSel = '0;
    for (int i = `MBX_WORDS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        nextSel = mbWordIdxT'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Select register
  //////////////////////////////////////////////////

  // Busy memory holds the select; loads keep piling up behind it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mbSel <= '0;
    end else if (!memBusy) begin
      mbSel <= nextSel;
    end
  end

  assign memReq = |pending;

  // Ack retires the selected word
  assign clrMask = (memAck && pending[mbSel]) ? (mbWordMaskT'(1) << mbSel) : '0;

  selHeldWhileBusy: assert property (
    @(posedge clk) disable iff (!rstN)
    memBusy |=> $stable(mbSel)
  ) else $error("drain select moved while memory busy");

  clrOneHot: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0(clrMask)
  ) else $error("more than one word cleared at once");

endmodule

// ==== verilog/mbxMemBuffer.sv ====
// Memory buffer top level: request producer, slot status, drain select and diag readout

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxMemBuffer
  import mbxBufferPkg::*;
  import mbxDiagPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       coreWdStrobe,
  input  mbWordIdxT  coreAdr,
  input  logic       cacheLoad,
  input  mbWordMaskT cacheWdMask,
  input  mbWordMaskT wdNeeded,
  input  logic       parBitIn,
  input  mbSourceT   mbInSel,
  input  logic       readRq,
  input  logic       oneWordRd,
  input  mbWordMaskT cshWdVal,
  input  mbWordIdxT  rdAdr,
  input  logic       memBusy,
  input  logic       memAck,
  input  logic       diagEn,
  input  diagSelT    diagSel,
  output mbWordIdxT  mbSel,
  output logic       memReq,
  output mbWordMaskT memRdMask,
  output diagWordT   diagData
);

  mbWordMaskT              wdLoad;
  logic                    loadPar;
  mbSourceT                loadSource;
  mbWordMaskT              pending;
  mbSlotT [`MBX_WORDS-1:0] slots;
  mbWordMaskT              clrMask;

  //////////////////////////////////////////////////
  // Load side
  //////////////////////////////////////////////////

  mbxWordRequest mbxWordRequest_i (
    .clk          (clk),
    .rstN         (rstN),
    .coreWdStrobe (coreWdStrobe),
    .cacheLoad    (cacheLoad),
    .readRq       (readRq),
    .oneWordRd    (oneWordRd),
    .coreAdr      (coreAdr),
    .rdAdr        (rdAdr),
    .cacheWdMask  (cacheWdMask),
    .wdNeeded     (wdNeeded),
    .cshWdVal     (cshWdVal),
    .parBitIn     (parBitIn),
    .mbInSel      (mbInSel),
    .wdLoad       (wdLoad),
    .loadPar      (loadPar),
    .loadSource   (loadSource),
    .memRdMask    (memRdMask)
  );

  mbxSlotStatus mbxSlotStatus_i (
    .clk        (clk),
    .rstN       (rstN),
    .wdLoad     (wdLoad),
    .clrMask    (clrMask),
    .loadPar    (loadPar),
    .loadSource (loadSource),
    .pending    (pending),
    .slots      (slots)
  );

  //////////////////////////////////////////////////
  // Drain and diagnostics
  //////////////////////////////////////////////////

  mbxDrainSelect mbxDrainSelect_i (
    .clk     (clk),
    .rstN    (rstN),
    .pending (pending),
    .memBusy (memBusy),
    .memAck  (memAck),
    .mbSel   (mbSel),
    .memReq  (memReq),
    .clrMask (clrMask)
  );

  mbxDiagRead mbxDiagRead_i (
    .diagEn    (diagEn),
    .diagSel   (diagSel),
    .slots     (slots),
    .pending   (pending),
    .memRdMask (memRdMask),
    .mbSel     (mbSel),
    .memReq    (memReq),
    .diagData  (diagData)
  );

endmodule

// ==== verilog/mbxSlotStatus.sv ====
// Four-slot buffer status: pending, parity and data code per word

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxSlotStatus
  import mbxBufferPkg::*;
(
  input  logic                        clk,
  input  logic                        rstN,
  input  mbWordMaskT                  wdLoad,
  input  mbWordMaskT                  clrMask,
  input  logic                        loadPar,
  input  mbSourceT                    loadSource,
  output mbWordMaskT                  pending,
  output mbSlotT [`MBX_WORDS-1:0]     slots
);

  mbWordMaskT pendingQ;
  mbWordMaskT parQ;
  mbDataCodeT codeQ [`MBX_WORDS];
  mbDataCodeT loadCode;

  // Source to data code
  always_comb begin
    case (loadSource)
      cacheData: loadCode = codeCache;
      arData:    loadCode = codeAr;
      memData:   loadCode = codeMem;
      chanData:  loadCode = codeExt;
      ccwData:   loadCode = codeExt;
      default:   loadCode = codeExt;
    endcase
  end

  //////////////////////////////////////////////////
  // Pending bits
  //////////////////////////////////////////////////

  // A load on the same edge as a clear keeps the word pending
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pendingQ <= '0;
    end else begin
      pendingQ <= (pendingQ & ~clrMask) | wdLoad;
    end
  end

  // Parity and code are written with each loaded word
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MBX_WORDS; i++) begin
      if (wdLoad[i]) begin
        parQ[i]  <= loadPar;
        codeQ[i] <= loadCode;
      end
    end
  end

  assign pending = pendingQ;

  always_comb begin
    for (int i = 0; i < `MBX_WORDS; i++) begin
      slots[i].fields.pending  = pendingQ[i];
      slots[i].fields.parity   = parQ[i];
      slots[i].fields.dataCode = codeQ[i];
    end
  end

  // Drain side only ever acknowledges a word that is waiting
  clrOnlyPending: assert property (
    @(posedge clk) disable iff (!rstN)
    (clrMask & ~pendingQ) == '0
  ) else $error("clear of a word that is not pending");

endmodule

// ==== verilog/mbxWordRequest.sv ====
// Word request producer: load mask with parity and source, memory read request mask

`timescale 1ns/1ps
`include "mbx_config.svh"

module mbxWordRequest
  import mbxBufferPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       coreWdStrobe,
  input  logic       cacheLoad,
  input  logic       readRq,
  input  logic       oneWordRd,
  input  mbWordIdxT  coreAdr,
  input  mbWordIdxT  rdAdr,
  input  mbWordMaskT cacheWdMask,
  input  mbWordMaskT wdNeeded,
  input  mbWordMaskT cshWdVal,
  input  logic       parBitIn,
  input  mbSourceT   mbInSel,
  output mbWordMaskT wdLoad,
  output logic       loadPar,
  output mbSourceT   loadSource,
  output mbWordMaskT memRdMask
);

  mbWordMaskT coreWd;
  mbWordMaskT cacheWd;
  mbWordMaskT oneWd;
  mbWordMaskT rdMaskNext;

  // One-hot word mask from a word address
  function automatic mbWordMaskT decodeIdx(input mbWordIdxT idx);
    mbWordMaskT m;
    m = '0;
    m[idx] = 1'b1;
    return m;
  endfunction

  //////////////////////////////////////////////////
  // Load request
  //////////////////////////////////////////////////

  assign coreWd  = coreWdStrobe ? decodeIdx(coreAdr) : '0;
  // Cache only supplies the words the cycle asked for
  assign cacheWd = cacheLoad ? (cacheWdMask & wdNeeded) : '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wdLoad <= '0;
    end else begin
      wdLoad <= coreWd | cacheWd;
    end
  end

  // Parity and source ride along with the load mask
  always_ff @(posedge clk) begin
    loadPar    <= parBitIn;
    loadSource <= mbInSel;
  end

  //////////////////////////////////////////////////
  // Memory read request
  //////////////////////////////////////////////////

  assign oneWd = decodeIdx(rdAdr);

  always_comb begin
    if (oneWordRd) begin
      rdMaskNext = oneWd;
    end else if (readRq) begin
      // Words the cache cannot supply
      rdMaskNext = ~cshWdVal & wdNeeded;
    end else begin
      rdMaskNext = '0;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memRdMask <= '0;
    end else begin
      memRdMask <= rdMaskNext;
    end
  end

endmodule

// ==== verilog/mbx_config.svh ====
// Memory buffer word count, index width and diagnostic readout widths

`ifndef MBX_CONFIG_SVH
`define MBX_CONFIG_SVH

// Number of words held in the memory buffer
`define MBX_WORDS 4

// Width of a buffer word address
`define MBX_IDX_W 2

// Diagnostic select and readout lane
`define MBX_DIAG_SEL_W 3
`define MBX_DIAG_W 4

`endif
